// ==== Makefile ====
# Verilator build and run of the cipher machine testbench.
VERILATOR ?= verilator
TOP ?= cipher_machine_tb
LOG ?= sim.log
BUILD_DIR ?= build
FILE_LIST ?= verilog.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run into $(LOG), check for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP LOG BUILD_DIR FILE_LIST"

test:
	$(VERILATOR) --binary --assert --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/cipher_machine_assertions.sv ====
// Protocol checks on the run and verifier pulses, bound into every cipher_machine instance.
`timescale 1ns/1ps

module cipher_machine_assertions (
	input logic clock,
	input logic resetn,
	input logic busy,
	input logic done,
	input logic checked
);

	// Done is a single cycle pulse.
	done_one_cycle: assert property (@(posedge clock) disable iff (!resetn)
		done |=> !done)
		else $error("done stayed high for more than one cycle");

	// Busy only falls on the cycle done is high.
	busy_falls_with_done: assert property (@(posedge clock) disable iff (!resetn)
		$fell(busy) |-> done)
		else $error("busy fell without done");

	// And done never comes without busy falling.
	done_drops_busy: assert property (@(posedge clock) disable iff (!resetn)
		done |-> $fell(busy))
		else $error("done came while busy did not fall");

	checked_one_cycle: assert property (@(posedge clock) disable iff (!resetn)
		checked |=> !checked)
		else $error("checked stayed high for more than one cycle"); // Verifier pulse.

endmodule

bind cipher_machine cipher_machine_assertions u_assertions (
	.clock(clock),
	.resetn(resetn),
	.busy(busy),
	.done(done),
	.checked(checked)
);

// ==== tests/cipher_machine_tb.sv ====
// Directed testbench for the cipher machine, runs every method and the verifier against a model.
`timescale 1ns/1ps

module cipher_machine_tb;

	localparam int NUM_LETTERS = 5;
	localparam int LB = cipher_pkg::LETTER_BITS;
	localparam int WB = NUM_LETTERS * LB;
	localparam int TIMEOUT_CYCLES = 40; // Longest run is about seven cycles.
	localparam int BANK_TEXT = 0;
	localparam int BANK_KEY = 1;
	localparam int BANK_GUESS = 2;

	logic clock;
	logic resetn;
	cipher_pkg::letter_t letter;
	logic load_text;
	logic load_key;
	logic load_guess;
	cipher_pkg::method_e method;
	logic decode;
	logic go;
	logic check;
	logic [WB-1:0] result;
	logic busy;
	logic done;
	logic checked;
	logic match;

	int error_count;
	int timeout_count;
	int done_count; // Done pulses since reset.
	int done_before;
	logic [WB-1:0] text;
	logic [WB-1:0] key;
	logic [WB-1:0] coded;
	cipher_pkg::letter_t new_first; // Replacement for slot 0.

	cipher_machine #(.NUM_LETTERS(NUM_LETTERS)) u_dut (
		.clock(clock),
		.resetn(resetn),
		.letter(letter),
		.load_text(load_text),
		.load_key(load_key),
		.load_guess(load_guess),
		.method(method),
		.decode(decode),
		.go(go),
		.check(check),
		.result(result),
		.busy(busy),
		.done(done),
		.checked(checked),
		.match(match)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock; // 8 ns period.
	end

	// Counts done pulses, sampled before the edge updates them.
	always @(posedge clock)
	begin
		if (!resetn)
			done_count <= 0;
		else if (done === 1'b1)
			done_count <= done_count + 1;
	end

	// Letter shift from the rule, blank stays blank.
	function automatic cipher_pkg::letter_t model_shift(
		input cipher_pkg::letter_t c,
		input cipher_pkg::letter_t k,
		input logic dec
	);
		int pos;
		int amt;
		if (c == cipher_pkg::BLANK_LETTER)
			return cipher_pkg::BLANK_LETTER;
		pos = int'(c) - 1;
		amt = int'(k) % 26;
		if (dec)
			pos = pos - amt + 26; // Keep it positive.
		else
			pos = pos + amt;
		return cipher_pkg::letter_t'(pos % 26 + 1);
	endfunction

	// Expected word for a method, letter 0 in the top field.
	function automatic logic [WB-1:0] model_word(
		input logic [WB-1:0] t,
		input logic [WB-1:0] k,
		input cipher_pkg::method_e m,
		input logic dec
	);
		logic [WB-1:0] w;
		cipher_pkg::letter_t shift;
		w = t; // Pass keeps the text.
		for (int i = 0; i < NUM_LETTERS; i++)
		begin
			if (m == cipher_pkg::METHOD_CAESAR)
				shift = k[WB-1 -: LB]; // Key slot 0 for all.
			else
				shift = k[(NUM_LETTERS-1-i)*LB +: LB];
			if (m == cipher_pkg::METHOD_CAESAR || m == cipher_pkg::METHOD_VIGENERE)
				w[(NUM_LETTERS-1-i)*LB +: LB] = model_shift(t[(NUM_LETTERS-1-i)*LB +: LB],
					shift, dec);
		end
		return w;
	endfunction

	function automatic logic [WB-1:0] random_word(input bit with_blanks);
		logic [WB-1:0] w;
		for (int i = 0; i < NUM_LETTERS; i++)
		begin
			if (with_blanks)
				w[i*LB +: LB] = cipher_pkg::letter_t'($urandom % 27);
			else
				w[i*LB +: LB] = cipher_pkg::letter_t'($urandom % 26 + 1);
		end
		return w;
	endfunction

	task automatic expect_word(input string name, input logic [WB-1:0] expected,
		input logic [WB-1:0] actual);
		if (actual !== expected)
		begin
			$display("Error %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic expect_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("Error %s: expected %b, actual %b", name, expected, actual);
			error_count++;
		end
	endtask

	// One strobe for one cycle, called right after a falling edge.
	task automatic load_letter(input int bank, input cipher_pkg::letter_t value);
		letter = value;
		load_text = (bank == BANK_TEXT);
		load_key = (bank == BANK_KEY);
		load_guess = (bank == BANK_GUESS);
		@(negedge clock);
		load_text = 1'b0;
		load_key = 1'b0;
		load_guess = 1'b0;
	endtask

	task automatic load_word(input int bank, input logic [WB-1:0] word);
		for (int i = 0; i < NUM_LETTERS; i++)
			load_letter(bank, word[(NUM_LETTERS-1-i)*LB +: LB]); // Slot 0 first.
	endtask

	// Pulses go, optionally a second go while busy, then waits for done.
	task automatic run_cipher(input string name, input cipher_pkg::method_e m, input logic dec,
		input logic [WB-1:0] expected, input bit extra_go);
		int cycles;
		method = m;
		decode = dec;
		go = 1'b1;
		@(negedge clock);
		go = 1'b0;
		if (extra_go)
		begin
			@(negedge clock);
			expect_bit({name, "_busy"}, 1'b1, busy);
			method = cipher_pkg::METHOD_PASS; // Would change the result if taken.
			go = 1'b1;
			@(negedge clock);
			go = 1'b0;
		end
		cycles = 0;
		while (done !== 1'b1 && cycles < TIMEOUT_CYCLES)
		begin
			@(negedge clock);
			cycles++;
		end
		if (done !== 1'b1)
		begin
			$display("%s timed out waiting for done", name);
			timeout_count++;
		end
		else
			expect_word(name, expected, result); // Result is new with done.
		@(negedge clock);
	endtask

	task automatic check_guess(input string name, input logic expected_match);
		int cycles;
		check = 1'b1;
		@(negedge clock);
		check = 1'b0;
		cycles = 0;
		while (checked !== 1'b1 && cycles < TIMEOUT_CYCLES)
		begin
			@(negedge clock);
			cycles++;
		end
		if (checked !== 1'b1)
		begin
			$display("%s timed out waiting for checked", name);
			timeout_count++;
		end
		else
			expect_bit(name, expected_match, match);
		@(negedge clock);
	endtask

	initial
	begin
		void'($urandom(32'h33c3));
		error_count = 0;
		timeout_count = 0;
		resetn = 1'b0;
		letter = cipher_pkg::BLANK_LETTER;
		load_text = 1'b0;
		load_key = 1'b0;
		load_guess = 1'b0;
		method = cipher_pkg::METHOD_PASS;
		decode = 1'b0;
		go = 1'b0;
		check = 1'b0;
		key = '0;
		repeat (2) @(negedge clock); // Two rising edges in reset.
		resetn = 1'b1;

		// Reset state, then both pass codes.
		expect_word("reset_result", '0, result);
		expect_bit("reset_busy", 1'b0, busy);
		text = random_word(1'b0);
		key = {5'd5, 5'd11, 5'd2, 5'd19, 5'd8}; // Ciphers would change every letter.
		load_word(BANK_TEXT, text);
		load_word(BANK_KEY, key);
		run_cipher("pass", cipher_pkg::METHOD_PASS, 1'b0, text, 1'b0);
		text = random_word(1'b0);
		load_word(BANK_TEXT, text);
		run_cipher("pass_alt", cipher_pkg::METHOD_PASS_ALT, 1'b0, text, 1'b0);

		// Caesar, random round trip.
		text = random_word(1'b1);
		key = random_word(1'b0);
		load_word(BANK_TEXT, text);
		load_word(BANK_KEY, key);
		coded = model_word(text, key, cipher_pkg::METHOD_CAESAR, 1'b0);
		run_cipher("caesar_encode", cipher_pkg::METHOD_CAESAR, 1'b0, coded, 1'b0);
		load_word(BANK_TEXT, coded);
		run_cipher("caesar_decode", cipher_pkg::METHOD_CAESAR, 1'b1, text, 1'b0);

		// Caesar wrap past z, z y blank a x shifted by 3.
		text = {5'd26, 5'd25, 5'd0, 5'd1, 5'd24};
		key = {5'd3, 5'd7, 5'd7, 5'd7, 5'd7};
		load_word(BANK_TEXT, text);
		load_word(BANK_KEY, key);
		run_cipher("caesar_wrap", cipher_pkg::METHOD_CAESAR, 1'b0,
			{5'd3, 5'd2, 5'd0, 5'd4, 5'd1}, 1'b0);
		load_word(BANK_TEXT, {5'd3, 5'd2, 5'd0, 5'd4, 5'd1});
		run_cipher("caesar_unwrap", cipher_pkg::METHOD_CAESAR, 1'b1, text, 1'b0);

		// Vigenere round trip.
		text = random_word(1'b1);
		key = random_word(1'b0);
		load_word(BANK_TEXT, text);
		load_word(BANK_KEY, key);
		coded = model_word(text, key, cipher_pkg::METHOD_VIGENERE, 1'b0);
		run_cipher("vigenere_encode", cipher_pkg::METHOD_VIGENERE, 1'b0, coded, 1'b0);
		load_word(BANK_TEXT, coded);
		run_cipher("vigenere_decode", cipher_pkg::METHOD_VIGENERE, 1'b1, text, 1'b0);

		// Sixth load lands in slot 0, then a dropped go mid run.
		text = random_word(1'b0);
		load_word(BANK_TEXT, text);
		new_first = cipher_pkg::letter_t'(int'(text[WB-1 -: LB]) % 26 + 1); // Never the old one.
		load_letter(BANK_TEXT, new_first);
		text[WB-1 -: LB] = new_first;
		key = random_word(1'b0);
		load_word(BANK_KEY, key);
		coded = model_word(text, key, cipher_pkg::METHOD_VIGENERE, 1'b0);
		done_before = done_count;
		run_cipher("wrap_busy_go", cipher_pkg::METHOD_VIGENERE, 1'b0, coded, 1'b1);
		repeat (10) @(negedge clock); // Room for a wrong second run.
		if (done_count - done_before != 1)
		begin
			$display("Error wrap_busy_go_done: expected 1, actual %0d", done_count - done_before);
			error_count++;
		end
		expect_bit("wrap_busy_go_idle", 1'b0, busy);

		// Verifier, exact guess then one letter off.
		load_word(BANK_GUESS, coded);
		check_guess("verify_match", 1'b1);
		new_first = cipher_pkg::letter_t'(int'(coded[WB-1 -: LB]) % 26 + 1);
		load_letter(BANK_GUESS, new_first);
		check_guess("verify_mismatch", 1'b0);

		$display("Finished with %0d errors and %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== verilog.f ====
verilog/cipher_pkg.sv
verilog/letter_entry.sv
verilog/caesar_unit.sv
verilog/vigenere_unit.sv
verilog/result_select.sv
verilog/cipher_machine.sv
tests/cipher_machine_assertions.sv
tests/cipher_machine_tb.sv

// ==== verilog/caesar_unit.sv ====
// Caesar unit, shifts the whole text word by key letter 0 in a single registered step.
`timescale 1ns/1ps

module caesar_unit #(
	parameter int NUM_LETTERS = 5
) (
	input logic clock,
	input logic resetn,
	input logic start,
	input logic run_decode,
	input logic [NUM_LETTERS*cipher_pkg::LETTER_BITS-1:0] text_word,
	input logic [NUM_LETTERS*cipher_pkg::LETTER_BITS-1:0] key_word,
	output logic [NUM_LETTERS*cipher_pkg::LETTER_BITS-1:0] caesar_word,
	output logic caesar_done
);

	localparam int LB = cipher_pkg::LETTER_BITS;

	cipher_pkg::letter_t shift_key; // Key slot 0 only.

	// Top field of the key word.
	assign shift_key = key_word[NUM_LETTERS*LB-1 -: LB];

	// All letters shift in parallel.
	// The word is only written when a run starts.
	always_ff @(posedge clock)
	begin
		if (start)
		begin
			for (int i = 0; i < NUM_LETTERS; i++)
			begin
				caesar_word[i*LB +: LB] <= cipher_pkg::shift_letter(
					text_word[i*LB +: LB], shift_key, run_decode);
			end
		end
	end

	// Done follows start by one cycle.
	always_ff @(posedge clock)
	begin
		if (!resetn)
			caesar_done <= 1'b0;
		else
			caesar_done <= start; // Word valid together with done.
	end

endmodule

// ==== verilog/cipher_machine.sv ====
// Top level of the cipher machine, wires letter entry, both cipher units and the result selector.
`timescale 1ns/1ps

module cipher_machine #(
	parameter int NUM_LETTERS = 5
) (
	input logic clock,
	input logic resetn,
	input cipher_pkg::letter_t letter,
	input logic load_text,
	input logic load_key,
	input logic load_guess,
	input cipher_pkg::method_e method,
	input logic decode,
	input logic go,
	input logic check,
	output logic [NUM_LETTERS*cipher_pkg::LETTER_BITS-1:0] result,
	output logic busy,
	output logic done,
	output logic checked,
	output logic match
);

	localparam int WB = NUM_LETTERS * cipher_pkg::LETTER_BITS;

	logic [WB-1:0] text_word;
	logic [WB-1:0] key_word;
	logic [WB-1:0] guess_word;
	logic [WB-1:0] caesar_word;
	logic [WB-1:0] vigenere_word;
	logic caesar_done;
	logic vigenere_done;
	logic start; // Shared run start.
	logic run_decode; // Decode held for the run.

	letter_entry #(.NUM_LETTERS(NUM_LETTERS)) u_entry (
		.clock(clock),
		.resetn(resetn),
		.letter(letter),
		.load_text(load_text),
		.load_key(load_key),
		.load_guess(load_guess),
		.text_word(text_word),
		.key_word(key_word),
		.guess_word(guess_word)
	);

	// Both units run on every start.
	caesar_unit #(.NUM_LETTERS(NUM_LETTERS)) u_caesar (
		.clock(clock),
		.resetn(resetn),
		.start(start),
		.run_decode(run_decode),
		.text_word(text_word),
		.key_word(key_word),
		.caesar_word(caesar_word),
		.caesar_done(caesar_done)
	);

	vigenere_unit #(.NUM_LETTERS(NUM_LETTERS)) u_vigenere (
		.clock(clock),
		.resetn(resetn),
		.start(start),
		.run_decode(run_decode),
		.text_word(text_word),
		.key_word(key_word),
		.vigenere_word(vigenere_word),
		.vigenere_done(vigenere_done)
	);

	result_select #(.NUM_LETTERS(NUM_LETTERS)) u_select (
		.clock(clock),
		.resetn(resetn),
		.go(go),
		.check(check),
		.method(method),
		.decode(decode),
		.text_word(text_word),
		.guess_word(guess_word),
		.caesar_word(caesar_word),
		.caesar_done(caesar_done),
		.vigenere_word(vigenere_word),
		.vigenere_done(vigenere_done),
		.start(start),
		.run_decode(run_decode),
		.result(result),
		.busy(busy),
		.done(done),
		.checked(checked),
		.match(match)
	);

endmodule

// ==== verilog/cipher_pkg.sv ====
// Letter codes, method and state enums and the shift rule shared by both cipher units.
package cipher_pkg;

	localparam int LETTER_BITS = 5; // One letter code.
	localparam int ALPHABET_SIZE = 26; // Letters a through z.

	// Letter code, 1 for a up to 26 for z.
	typedef logic [LETTER_BITS-1:0] letter_t;

	localparam letter_t BLANK_LETTER = '0; // Empty slot, never shifted.

	// Run method as set on the method inputs.
	typedef enum logic [1:0] {
		METHOD_PASS = 2'd0, // Text unchanged.
		METHOD_CAESAR = 2'd1,
		METHOD_VIGENERE = 2'd2,
		METHOD_PASS_ALT = 2'd3 // Same as pass.
	} method_e;

	// Serial walker states.
	typedef enum logic [1:0] {
		VIG_IDLE = 2'd0,
		VIG_SHIFT = 2'd1,
		VIG_DONE = 2'd2
	} vigenere_state_e;

	// Shift one letter by k places modulo 26, backwards when decode is set.
	function automatic letter_t shift_letter(
		input letter_t c,
		input letter_t k,
		input logic decode
	);
		logic [5:0] pos;
		logic [5:0] amt;
		logic [5:0] sum;
		letter_t shifted;
		pos = 6'((c - 1) % ALPHABET_SIZE); // Zero based position.
		amt = 6'(k % ALPHABET_SIZE); // Key counts modulo 26.
		if (decode)
			sum = pos + 6'(ALPHABET_SIZE) - amt; // Add 26 first so it never goes negative.
		else
			sum = pos + amt;
		if (sum >= 6'(ALPHABET_SIZE))
			sum = sum - 6'(ALPHABET_SIZE); // Wrap past z.
		shifted = letter_t'(sum + 6'd1);
		// Blanks pass through.
		if (c == BLANK_LETTER)
			shifted = BLANK_LETTER;
		return shifted;
	endfunction

endpackage

// ==== verilog/letter_entry.sv ====
// Letter entry, loads text, key and guess banks one letter per strobe from the letter port.
`timescale 1ns/1ps

module letter_entry #(
	parameter int NUM_LETTERS = 5
) (
	input logic clock,
	input logic resetn,
	input cipher_pkg::letter_t letter,
	input logic load_text,
	input logic load_key,
	input logic load_guess,
	output logic [NUM_LETTERS*cipher_pkg::LETTER_BITS-1:0] text_word,
	output logic [NUM_LETTERS*cipher_pkg::LETTER_BITS-1:0] key_word,
	output logic [NUM_LETTERS*cipher_pkg::LETTER_BITS-1:0] guess_word
);

	localparam int IDX_BITS = (NUM_LETTERS > 1) ? $clog2(NUM_LETTERS) : 1;
	localparam int NUM_BANKS = 3;
	localparam int LB = cipher_pkg::LETTER_BITS;

	// Bank 0 text, bank 1 key, bank 2 guess.
	cipher_pkg::letter_t bank [NUM_BANKS][NUM_LETTERS];
	logic [IDX_BITS-1:0] wr_idx [NUM_BANKS]; // Next slot per bank.
	logic [NUM_BANKS-1:0] load;

	assign load = {load_guess, load_key, load_text};

	// Each strobe writes its own bank and moves only that index.
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			for (int b = 0; b < NUM_BANKS; b++)
			begin
				for (int i = 0; i < NUM_LETTERS; i++)
					bank[b][i] <= cipher_pkg::BLANK_LETTER; // All slots blank.
				wr_idx[b] <= '0;
			end
		end
		else
		begin
			for (int b = 0; b < NUM_BANKS; b++)
			begin
				if (load[b])
				begin
					bank[b][wr_idx[b]] <= letter;
					// Last slot wraps to slot 0.
					if (wr_idx[b] == IDX_BITS'(NUM_LETTERS - 1))
						wr_idx[b] <= '0;
					else
						wr_idx[b] <= wr_idx[b] + 1'b1;
				end
			end
		end
	end

	// Letter 0 goes in the top field of each word.
	always_comb
	begin
		for (int i = 0; i < NUM_LETTERS; i++)
		begin
			text_word[(NUM_LETTERS-1-i)*LB +: LB] = bank[0][i];
			key_word[(NUM_LETTERS-1-i)*LB +: LB] = bank[1][i];
			guess_word[(NUM_LETTERS-1-i)*LB +: LB] = bank[2][i];
		end
	end

endmodule

// ==== verilog/result_select.sv ====
// Run control and verifier, starts runs, picks the method's result and compares it with the guess.
`timescale 1ns/1ps

module result_select #(
	parameter int NUM_LETTERS = 5
) (
	input logic clock,
	input logic resetn,
	input logic go,
	input logic check,
	input cipher_pkg::method_e method,
	input logic decode,
	input logic [NUM_LETTERS*cipher_pkg::LETTER_BITS-1:0] text_word,
	input logic [NUM_LETTERS*cipher_pkg::LETTER_BITS-1:0] guess_word,
	input logic [NUM_LETTERS*cipher_pkg::LETTER_BITS-1:0] caesar_word,
	input logic caesar_done,
	input logic [NUM_LETTERS*cipher_pkg::LETTER_BITS-1:0] vigenere_word,
	input logic vigenere_done,
	output logic start,
	output logic run_decode,
	output logic [NUM_LETTERS*cipher_pkg::LETTER_BITS-1:0] result,
	output logic busy,
	output logic done,
	output logic checked,
	output logic match
);

	localparam int WB = NUM_LETTERS * cipher_pkg::LETTER_BITS;

	cipher_pkg::method_e method_q; // Method of the current run.
	logic [WB-1:0] text_q; // Text seen at start, for pass.
	logic admit;
	logic finish;
	logic [WB-1:0] pick;

	// A go while busy is dropped.
	assign admit = go && !busy;

	// End of run for the latched method.
	always_comb
	begin
		case (method_q)
			cipher_pkg::METHOD_CAESAR:
			begin
				finish = busy && caesar_done;
				pick = caesar_word;
			end
			cipher_pkg::METHOD_VIGENERE:
			begin
				finish = busy && vigenere_done;
				pick = vigenere_word;
			end
			default:
			begin
				finish = busy && start; // Pass needs no unit.
				pick = text_q;
			end
		endcase
	end

	// Run sequencing.
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			start <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			run_decode <= 1'b0;
			method_q <= cipher_pkg::METHOD_PASS;
			result <= '0; // Blank word.
		end
		else
		begin
			start <= admit;
			done <= finish;
			if (admit)
			begin
				busy <= 1'b1;
				run_decode <= decode;
				method_q <= method;
			end
			else if (finish)
			begin
				busy <= 1'b0; // Falls with done rising.
				result <= pick;
			end
		end
	end

	// Text snapshot for pass runs.
	always_ff @(posedge clock)
	begin
		if (admit)
			text_q <= text_word;
	end

	// Verifier.
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			checked <= 1'b0;
			match <= 1'b0;
		end
		else
		begin
			checked <= check;
			if (check)
				match <= (guess_word == result); // Compare against held result.
		end
	end

endmodule

// ==== verilog/vigenere_unit.sv ====
// Vigenere unit, walks the text one letter per cycle using the key letter at the same position.
`timescale 1ns/1ps

module vigenere_unit #(
	parameter int NUM_LETTERS = 5
) (
	input logic clock,
	input logic resetn,
	input logic start,
	input logic run_decode,
	input logic [NUM_LETTERS*cipher_pkg::LETTER_BITS-1:0] text_word,
	input logic [NUM_LETTERS*cipher_pkg::LETTER_BITS-1:0] key_word,
	output logic [NUM_LETTERS*cipher_pkg::LETTER_BITS-1:0] vigenere_word,
	output logic vigenere_done
);

	localparam int IDX_BITS = (NUM_LETTERS > 1) ? $clog2(NUM_LETTERS) : 1;
	localparam int LB = cipher_pkg::LETTER_BITS;
	localparam int WB = NUM_LETTERS * LB;

	cipher_pkg::vigenere_state_e state;
	logic [IDX_BITS-1:0] idx; // Letter being written.
	logic [WB-1:0] text_q; // Text held for the walk.
	logic [WB-1:0] key_q;
	logic decode_q;
	logic [WB-1:0] src_text;
	logic [WB-1:0] src_key;
	logic src_decode;
	logic write_en;
	logic last_letter;

	// Letter 0 is taken straight from the inputs on the start edge.
	// Later letters come from the held copies.
	assign src_text = (state == cipher_pkg::VIG_IDLE) ? text_word : text_q;
	assign src_key = (state == cipher_pkg::VIG_IDLE) ? key_word : key_q;
	assign src_decode = (state == cipher_pkg::VIG_IDLE) ? run_decode : decode_q;

	assign write_en = ((state == cipher_pkg::VIG_IDLE) && start) ||
		(state == cipher_pkg::VIG_SHIFT);
	assign last_letter = (idx == IDX_BITS'(NUM_LETTERS - 1));
	assign vigenere_done = (state == cipher_pkg::VIG_DONE); // One cycle after last write.

	// Walker FSM.
	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			state <= cipher_pkg::VIG_IDLE;
			idx <= '0;
		end
		else
		begin
			case (state)
				cipher_pkg::VIG_IDLE:
				begin
					if (start)
					begin
						// Letter 0 written on this edge.
						if (last_letter)
							state <= cipher_pkg::VIG_DONE;
						else
						begin
							idx <= idx + 1'b1;
							state <= cipher_pkg::VIG_SHIFT;
						end
					end
				end
				cipher_pkg::VIG_SHIFT:
				begin
					if (last_letter)
					begin
						idx <= '0; // Ready for next run.
						state <= cipher_pkg::VIG_DONE;
					end
					else
						idx <= idx + 1'b1;
				end
				cipher_pkg::VIG_DONE:
					state <= cipher_pkg::VIG_IDLE;
				default:
					state <= cipher_pkg::VIG_IDLE;
			endcase
		end
	end

	// Held operands and the output word.
	always_ff @(posedge clock)
	begin
		if ((state == cipher_pkg::VIG_IDLE) && start)
		begin
			text_q <= text_word;
			key_q <= key_word;
			decode_q <= run_decode;
		end
		if (write_en)
			vigenere_word[(NUM_LETTERS-1-idx)*LB +: LB] <= cipher_pkg::shift_letter(
				src_text[(NUM_LETTERS-1-idx)*LB +: LB],
				src_key[(NUM_LETTERS-1-idx)*LB +: LB],
				src_decode);
	end

endmodule
